// ==== filelist.f ====
+incdir+.
rv32i_types.sv
br_unit.sv
branch_dispatch.sv
branch_station_fifo.sv
branch_exec.sv
branch_cluster_top.sv
tb_branch_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the branch cluster testbench with Verilator, run it, then scan the log
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_branch_cluster \
    -o tb_branch_cluster > build.log 2>&1 \
    && ./obj_dir/tb_branch_cluster > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb_branch_cluster.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module tb_branch_cluster
    import rv32i_types::*;
    ();

    // per test cycle budgets summed for the run limit
    localparam int test_len   = 5 + 4 * 8 + 18 * 8 + 20 + 30 + 30 + 2 * 8;
    localparam int max_cycles = test_len + 200;

    logic          clk;
    logic          rst_n;
    logic          disp_valid;
    dispatch_req_t disp_req;
    logic          disp_ready;
    logic          wb_valid;
    to_writeback_t wb_out;
    logic          wb_ready;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;

    logic [31:0]              lfsr;
    logic [`BR_ROB_IDX_W-1:0] rob_tag;
    to_writeback_t            exp_q[$];
    to_writeback_t            mon_exp;
    string                    test_name = "reset";
    int                       cycles = 0;
    int                       redirects = 0;
    int                       first_disp_cyc = -1;
    int                       first_wb_cyc = -1;
    int                       first_xfer_cyc = -1;
    int                       last_wb_cyc = -1;

    branch_cluster_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .disp_valid     (disp_valid),
        .disp_req       (disp_req),
        .disp_ready     (disp_ready),
        .wb_valid       (wb_valid),
        .wb_out         (wb_out),
        .wb_ready       (wb_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // even offset sign extended from the given width
    function automatic logic [31:0] rand_imm(input int bits);
        logic [31:0] v;
        v = rand_bits(bits - 1) << 1;
        v = v << (32 - bits);
        return $signed(v) >>> (32 - bits);
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] v;
        v = rand_bits(30);
        return {v[29:0], 2'b00};
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(input to_writeback_t exp, input to_writeback_t act);
        if (exp !== act) begin
            fail_now($sformatf("Error: %s writeback expected %p actual %p",
                               test_name, exp, act));
        end
    endtask

    task automatic check_redirect(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_now($sformatf("Error: %s redirect_pc expected %h actual %h",
                               test_name, exp, act));
        end
    endtask

    task automatic expect_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            fail_now($sformatf("Error: %s %s expected %b actual %b",
                               test_name, what, exp, act));
        end
    endtask

    task automatic expect_count(input string what, input int exp, input int act);
        if (exp != act) begin
            fail_now($sformatf("Error: %s %s expected %0d actual %0d",
                               test_name, what, exp, act));
        end
    endtask

    // encodes the word and predicts the resolved result
    task automatic model_branch(
        input rv32i_opcode_t op, input branch_funct3_t f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [31:0] imm, input logic [31:0] pc,
        input logic [31:0] a, input logic [31:0] b,
        input logic pred, input logic [31:0] ptgt,
        output dispatch_req_t req, output to_writeback_t exp);
        logic [31:0] word;
        logic [31:0] target;
        logic        taken;
        case (op)
            op_b_jal:  word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
            op_b_jalr: word = {imm[11:0], rs1, 3'b000, rd, op};
            default:   word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
        endcase
        target = (op == op_b_jalr) ? a + imm : pc + imm;
        case (f3)
            branch_f3_beq:  taken = (a == b);
            branch_f3_bne:  taken = (a != b);
            branch_f3_blt:  taken = ($signed(a) < $signed(b));
            branch_f3_bge:  taken = ($signed(a) >= $signed(b));
            branch_f3_bltu: taken = (a < b);
            default:        taken = (a >= b);
        endcase
        if (op != op_b_br) begin
            taken = 1'b1;
        end
        req             = '0;
        req.inst        = word;
        req.pc          = pc;
        req.rs1_data    = a;
        req.rs2_data    = b;
        req.rd_rob_idx  = rob_tag;
        req.pred_taken  = pred;
        req.pred_target = ptgt;
        rob_tag         = rob_tag + 1'b1;
        exp             = '0;
        exp.valid       = 1'b1;
        exp.pc          = pc;
        exp.inst        = word;
        exp.prediction  = pred;
        exp.rd_addr     = (op == op_b_br) ? 5'd0 : rd;
        exp.rs1_addr    = (op == op_b_jal) ? 5'd0 : rs1;
        exp.rs2_addr    = (op == op_b_br) ? rs2 : 5'd0;
        exp.rd_rob_idx  = req.rd_rob_idx;
        exp.rd_data     = (op == op_b_br) ? 32'd0 : pc + 32'd4;
        exp.regf_we     = (op != op_b_br) && (rd != 5'd0);
        exp.br_en       = taken;
        exp.pc_new      = taken ? target : (pred ? ptgt : pc + 32'd4);
        exp.mispredict  = (taken != pred) || (taken && pred && (target != ptgt));
    endtask

    // bne on equal operands predicted not taken
    task automatic make_filler(output dispatch_req_t req, output to_writeback_t exp);
        logic [31:0] a;
        a = rand_bits(32);
        model_branch(op_b_br, branch_f3_bne, 5'd0, 5'd1, 5'd2, rand_imm(13), rand_pc(),
                     a, a, 1'b0, 32'd0, req, exp);
    endtask

    // starts and returns 1 ns after a rising edge
    task automatic send(input dispatch_req_t req);
        disp_valid = 1'b1;
        disp_req   = req;
        @(negedge clk);
        while (!disp_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic issue_and_drain(input dispatch_req_t req, input to_writeback_t exp);
        exp_q.push_back(exp);
        send(req);
        drain();
    endtask

    task automatic jumps_link();
        dispatch_req_t req;
        to_writeback_t exp;
        test_name = "jumps_link";
        model_branch(op_b_jal, branch_f3_beq, 5'd1, 5'd0, 5'd0, rand_imm(21), rand_pc(),
                     32'd0, 32'd0, 1'b0, 32'd0, req, exp);
        issue_and_drain(req, exp);
        model_branch(op_b_jal, branch_f3_beq, 5'd0, 5'd0, 5'd0, rand_imm(21), rand_pc(),
                     32'd0, 32'd0, 1'b0, 32'd0, req, exp);
        issue_and_drain(req, exp);
        model_branch(op_b_jalr, branch_f3_beq, 5'd5, 5'd3, 5'd0, rand_imm(12), rand_pc(),
                     rand_bits(32), 32'd0, 1'b0, 32'd0, req, exp);
        issue_and_drain(req, exp);
        model_branch(op_b_jalr, branch_f3_beq, 5'd0, 5'd7, 5'd0, rand_imm(12), rand_pc(),
                     rand_bits(32), 32'd0, 1'b0, 32'd0, req, exp);
        issue_and_drain(req, exp);
    endtask

    task automatic branch_conditions();
        dispatch_req_t  req;
        to_writeback_t  exp;
        branch_funct3_t codes [6];
        logic [31:0]    a;
        logic [31:0]    b;
        test_name = "branch_conditions";
        codes = '{branch_f3_beq, branch_f3_bne, branch_f3_blt,
                  branch_f3_bge, branch_f3_bltu, branch_f3_bgeu};
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                a = rand_bits(32);
                b = a;
                if (p == 1) begin
                    // negative against positive
                    a = a | 32'h8000_0000;
                    b = rand_bits(32) & 32'h7fff_ffff;
                end else if (p == 2) begin
                    a = a | 32'h8000_0000;
                    b = rand_bits(32) | 32'h8000_0000;
                end
                model_branch(op_b_br, codes[c], 5'd0, 5'd4, 5'd6, rand_imm(13), rand_pc(),
                             a, b, 1'b0, 32'd0, req, exp);
                issue_and_drain(req, exp);
            end
        end
    endtask

    task automatic latency_throughput();
        dispatch_req_t req;
        to_writeback_t exp;
        test_name      = "latency_throughput";
        first_disp_cyc = -1;
        first_wb_cyc   = -1;
        first_xfer_cyc = -1;
        for (int i = 0; i < 6; i++) begin
            make_filler(req, exp);
            exp_q.push_back(exp);
            send(req);
        end
        drain();
        expect_count("first result latency", 3, first_wb_cyc - first_disp_cyc);
        expect_count("result spacing", 5, last_wb_cyc - first_xfer_cyc);
    endtask

    task automatic backpressure_hold();
        dispatch_req_t req;
        to_writeback_t exp;
        int            accepted;
        test_name = "backpressure_hold";
        accepted  = 0;
        wb_ready  = 1'b0;
        for (int i = 0; i < 10; i++) begin
            make_filler(req, exp);
            disp_valid = 1'b1;
            disp_req   = req;
            @(negedge clk);
            if (!disp_ready) begin
                break;
            end
            @(posedge clk);
            #1;
            exp_q.push_back(exp);
            accepted++;
        end
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        expect_count("accepted while stalled", `BR_STATION_DEPTH + 2, accepted);
        wb_ready = 1'b1;
        drain();
    endtask

    task automatic mispredict_flush();
        dispatch_req_t req;
        to_writeback_t exp;
        logic [31:0]   a;
        int            base;
        test_name = "mispredict_flush";
        wb_ready  = 1'b0;
        a         = rand_bits(32);
        model_branch(op_b_br, branch_f3_beq, 5'd0, 5'd8, 5'd9, rand_imm(13), rand_pc(),
                     a, a, 1'b0, 32'd0, req, exp);
        exp_q.push_back(exp);
        send(req);
        // wrong path entries that the flush drops
        for (int i = 0; i < 3; i++) begin
            make_filler(req, exp);
            send(req);
        end
        repeat (3) @(posedge clk);
        #1;
        base     = redirects;
        wb_ready = 1'b1;
        drain();
        expect_count("redirect pulses", base + 1, redirects);
        make_filler(req, exp);
        issue_and_drain(req, exp);
    endtask

    task automatic predicted_taken();
        dispatch_req_t req;
        to_writeback_t exp;
        logic [31:0]   pc;
        logic [31:0]   imm;
        int            base;
        test_name = "predicted_taken";
        base      = redirects;
        model_branch(op_b_br, branch_f3_beq, 5'd0, 5'd1, 5'd2, rand_imm(13), rand_pc(),
                     32'd1, 32'd2, 1'b1, rand_pc(), req, exp);
        issue_and_drain(req, exp);
        expect_count("redirects after not taken", base + 1, redirects);
        pc  = rand_pc();
        imm = rand_imm(21);
        model_branch(op_b_jal, branch_f3_beq, 5'd1, 5'd0, 5'd0, imm, pc,
                     32'd0, 32'd0, 1'b1, pc + imm, req, exp);
        issue_and_drain(req, exp);
        expect_count("redirects after correct jal", base + 1, redirects);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            fail_now($sformatf("run did not finish within %0d cycles", max_cycles));
        end
    end

    // results and redirects checked at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (disp_valid && disp_ready && first_disp_cyc < 0) begin
                first_disp_cyc = cycles;
            end
            if (wb_valid && first_wb_cyc < 0) begin
                first_wb_cyc = cycles;
            end
            if (redirect_valid) begin
                redirects++;
                expect_flag("disp_ready during redirect", 1'b0, disp_ready);
            end
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    fail_now($sformatf("unexpected result for pc %h in %s",
                                       wb_out.pc, test_name));
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_wb(mon_exp, wb_out);
                    expect_flag("redirect_valid", mon_exp.mispredict, redirect_valid);
                    if (mon_exp.mispredict) begin
                        check_redirect(mon_exp.br_en ? mon_exp.pc_new : mon_exp.pc + 32'd4,
                                       redirect_pc);
                    end
                    if (first_xfer_cyc < 0) begin
                        first_xfer_cyc = cycles;
                    end
                    last_wb_cyc = cycles;
                end
            end else begin
                expect_flag("redirect_valid while idle", 1'b0, redirect_valid);
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        disp_valid = 1'b0;
        disp_req   = '0;
        wb_ready   = 1'b1;
        lfsr       = 32'd10368;
        rob_tag    = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_flag("disp_ready after reset", 1'b1, disp_ready);
        expect_flag("wb_valid after reset", 1'b0, wb_valid);
        expect_flag("redirect_valid after reset", 1'b0, redirect_valid);

        jumps_link();
        branch_conditions();
        latency_throughput();
        backpressure_hold();
        mispredict_flush();
        predicted_taken();

        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "results missing at end of run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== branch_cluster_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_cluster_top
    import rv32i_types::*;
    (
        input  logic          clk,
        input  logic          rst_n,
        input  logic          disp_valid,
        input  dispatch_req_t disp_req,
        output logic          disp_ready,
        output logic          wb_valid,
        output to_writeback_t wb_out,
        input  logic          wb_ready,
        output logic          redirect_valid,
        output logic [31:0]   redirect_pc
    );

    logic                 ent_valid;
    logic                 ent_ready;
    reservation_station_t ent;
    logic                 head_valid;
    logic                 head_ready;
    reservation_station_t head;

    branch_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_valid (disp_valid),
        .disp_req   (disp_req),
        .disp_ready (disp_ready),
        .flush      (redirect_valid),
        .ent_valid  (ent_valid),
        .ent        (ent),
        .ent_ready  (ent_ready)
    );

    branch_station_fifo u_station (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect_valid),
        .ent_valid  (ent_valid),
        .ent        (ent),
        .ent_ready  (ent_ready),
        .head_valid (head_valid),
        .head       (head),
        .head_ready (head_ready)
    );

    // redirect doubles as the upstream flush
    branch_exec u_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .head_valid     (head_valid),
        .head           (head),
        .head_ready     (head_ready),
        .wb_valid       (wb_valid),
        .wb_out         (wb_out),
        .wb_ready       (wb_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== branch_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module branch_exec
    import rv32i_types::*;
    (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 head_valid,
        input  reservation_station_t head,
        output logic                 head_ready,
        output logic                 wb_valid,
        output to_writeback_t        wb_out,
        input  logic                 wb_ready,
        output logic                 redirect_valid,
        output logic [31:0]          redirect_pc
    );

    reservation_station_t next_execute;
    to_writeback_t        execute_output;
    to_writeback_t        resolved;

    // stale station slots must not look valid
    always_comb begin
        next_execute       = head;
        next_execute.valid = head_valid;
    end

    br_unit u_br_unit (
        .next_execute   (next_execute),
        .execute_output (execute_output)
    );

    always_comb begin
        resolved            = execute_output;
        resolved.mispredict = (execute_output.br_en != head.prediction) ||
                              (execute_output.br_en && head.prediction &&
                               (execute_output.pc_new != head.pc_new));
    end

    // the entry behind a mispredict is wrong path, keep it out
    assign head_ready = !wb_valid || (wb_ready && !wb_out.mispredict);

    assign redirect_valid = wb_valid && wb_ready && wb_out.mispredict;
    assign redirect_pc    = wb_out.br_en ? wb_out.pc_new : wb_out.pc + `BR_LINK_OFFSET;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (head_ready) begin
            wb_valid <= head_valid;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (head_ready && head_valid) begin
            wb_out <= resolved;
        end
    end

endmodule

`default_nettype wire

// ==== branch_station_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module branch_station_fifo
    import rv32i_types::*;
    (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 flush,
        input  logic                 ent_valid,
        input  reservation_station_t ent,
        output logic                 ent_ready,
        output logic                 head_valid,
        output reservation_station_t head,
        input  logic                 head_ready
    );

    localparam int DEPTH = `BR_STATION_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    reservation_station_t entries [DEPTH];

    // extra msb is the wrap bit
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           do_wr;
    logic           do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // a full station still takes a write when the head leaves
    assign ent_ready  = !full || head_ready;
    assign head_valid = !empty;
    assign head       = entries[rd_ptr[PTR_W-1:0]];

    assign do_wr = ent_valid && ent_ready;
    assign do_rd = head_valid && head_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            entries[wr_ptr[PTR_W-1:0]] <= ent;
        end
    end

endmodule

`default_nettype wire

// ==== branch_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module branch_dispatch
    import rv32i_types::*;
    (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 disp_valid,
        input  dispatch_req_t        disp_req,
        output logic                 disp_ready,
        input  logic                 flush,
        output logic                 ent_valid,
        output reservation_station_t ent,
        input  logic                 ent_ready
    );

    inst_word_u           word;
    reservation_station_t dec;

    assign word = disp_req.inst;

    // nothing enters on the redirect edge
    assign disp_ready = !flush && (!ent_valid || ent_ready);

    always_comb begin
        dec            = '0;
        dec.valid      = 1'b1;
        dec.opcode     = rv32i_opcode_t'(word.i_view.opcode);
        dec.brop       = branch_funct3_t'(word.i_view.funct3);
        dec.pc         = disp_req.pc;
        dec.inst       = word;
        dec.rs1_data   = disp_req.rs1_data;
        dec.rs2_data   = disp_req.rs2_data;
        dec.rd_rob_idx = disp_req.rd_rob_idx;
        dec.prediction = disp_req.pred_taken;

        unique case (dec.opcode)
            op_b_jal: begin
                dec.imm_sext = {{12{word.bj_view.imm_hi[6]}}, word.bj_view.rs1,
                                word.bj_view.funct3, word.bj_view.rs2[0],
                                word.bj_view.imm_hi[5:0], word.bj_view.rs2[4:1], 1'b0};
                dec.rd_addr  = word.i_view.rd;
                dec.regf_we  = (word.i_view.rd != 5'd0);
            end
            op_b_jalr: begin
                dec.imm_sext = {{20{word.i_view.imm_11_0[11]}}, word.i_view.imm_11_0};
                dec.rd_addr  = word.i_view.rd;
                dec.rs1_addr = word.i_view.rs1;
                dec.regf_we  = (word.i_view.rd != 5'd0);
            end
            op_b_br: begin
                dec.imm_sext = {{20{word.bj_view.imm_hi[6]}}, word.bj_view.imm_lo[0],
                                word.bj_view.imm_hi[5:0], word.bj_view.imm_lo[4:1], 1'b0};
                dec.rs1_addr = word.bj_view.rs1;
                dec.rs2_addr = word.bj_view.rs2;
            end
            default: begin
                // not a branch, resolves as a no-op
                dec.imm_sext = '0;
            end
        endcase

        dec.pc_new = disp_req.pred_taken ? disp_req.pred_target
                                         : disp_req.pc + `BR_LINK_OFFSET;
    end

    // one-entry skid register
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ent_valid <= 1'b0;
        end else if (disp_valid && disp_ready) begin
            ent_valid <= 1'b1;
        end else if (ent_ready) begin
            ent_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid && disp_ready) begin
            ent <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== br_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module br_unit
    import rv32i_types::*;
    (
        input  reservation_station_t next_execute,
        output to_writeback_t        execute_output
    );

    logic [31:0] base;
    logic [31:0] offset;
    logic [31:0] target;
    logic [31:0] link_data;
    logic        br_en;
    logic        rs_eq;
    logic        rs_lt_s;
    logic        rs_lt_u;

    // shared comparators for the six conditions
    assign rs_eq   = (next_execute.rs1_data == next_execute.rs2_data);
    assign rs_lt_s = ($signed(next_execute.rs1_data) < $signed(next_execute.rs2_data));
    assign rs_lt_u = (next_execute.rs1_data < next_execute.rs2_data);

    always_comb begin
        base      = '0;
        offset    = '0;
        br_en     = 1'b0;
        link_data = '0;

        if (next_execute.valid) begin
            unique case (next_execute.opcode)
                op_b_jal: begin
                    base      = next_execute.pc;
                    offset    = next_execute.imm_sext;
                    br_en     = 1'b1;
                    link_data = next_execute.pc + `BR_LINK_OFFSET;
                end
                op_b_jalr: begin
                    // register relative jump
                    base      = next_execute.rs1_data;
                    offset    = next_execute.imm_sext;
                    br_en     = 1'b1;
                    link_data = next_execute.pc + `BR_LINK_OFFSET;
                end
                op_b_br: begin
                    base   = next_execute.pc;
                    offset = next_execute.imm_sext;
                    unique case (next_execute.brop)
                        branch_f3_beq:  br_en = rs_eq;
                        branch_f3_bne:  br_en = !rs_eq;
                        branch_f3_blt:  br_en = rs_lt_s;
                        branch_f3_bge:  br_en = !rs_lt_s;
                        branch_f3_bltu: br_en = rs_lt_u;
                        branch_f3_bgeu: br_en = !rs_lt_u;
                        default:        br_en = 1'b0;
                    endcase
                end
                default: begin
                    br_en = 1'b0;
                end
            endcase
        end
    end

    assign target = base + offset;

    always_comb begin
        execute_output = '0;
        if (next_execute.valid) begin
            execute_output.valid      = 1'b1;
            execute_output.pc         = next_execute.pc;
            execute_output.inst       = next_execute.inst;
            execute_output.prediction = next_execute.prediction;
            execute_output.rd_addr    = next_execute.rd_addr;
            execute_output.rs1_addr   = next_execute.rs1_addr;
            execute_output.rs2_addr   = next_execute.rs2_addr;
            execute_output.rd_rob_idx = next_execute.rd_rob_idx;
            execute_output.rd_data    = link_data;
            execute_output.regf_we    = next_execute.regf_we;
            execute_output.br_en      = br_en;
            // not taken keeps the front end's guess
            execute_output.pc_new     = br_en ? target : next_execute.pc_new;
        end
    end

endmodule

`default_nettype wire

// ==== rv32i_types.sv ====
`default_nettype none

`include "br_cfg.svh"

package rv32i_types;

    // major opcodes seen by the branch cluster
    typedef enum logic [6:0] {
        op_b_jal  = 7'b1101111,
        op_b_jalr = 7'b1100111,
        op_b_br   = 7'b1100011
    } rv32i_opcode_t;

    // funct3 encodings of the conditional branches
    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_funct3_t;

    // I-type layout, used for jalr
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // B/J-type layout, scattered immediate bits
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_bj_t;

    typedef union packed {
        inst_i_t  i_view;
        inst_bj_t bj_view;
    } inst_word_u;

    // what the rename/issue side hands to the cluster
    typedef struct packed {
        inst_word_u                inst;
        logic [31:0]               pc;
        logic [31:0]               rs1_data;
        logic [31:0]               rs2_data;
        logic [`BR_ROB_IDX_W-1:0]  rd_rob_idx;
        logic                      pred_taken;
        logic [31:0]               pred_target;
    } dispatch_req_t;

    typedef struct packed {
        logic                      valid;
        rv32i_opcode_t             opcode;
        branch_funct3_t            brop;
        logic [31:0]               pc;
        logic [31:0]               inst;
        logic [31:0]               imm_sext;
        logic [31:0]               rs1_data;
        logic [31:0]               rs2_data;
        logic [4:0]                rd_addr;
        logic [4:0]                rs1_addr;
        logic [4:0]                rs2_addr;
        logic [`BR_ROB_IDX_W-1:0]  rd_rob_idx;
        logic                      regf_we;
        logic                      prediction;
        // predicted next pc
        logic [31:0]               pc_new;
    } reservation_station_t;

    typedef struct packed {
        logic                      valid;
        logic [31:0]               pc;
        logic [31:0]               inst;
        logic                      prediction;
        logic [4:0]                rd_addr;
        logic [4:0]                rs1_addr;
        logic [4:0]                rs2_addr;
        logic [`BR_ROB_IDX_W-1:0]  rd_rob_idx;
        logic [31:0]               rd_data;
        logic                      regf_we;
        logic                      br_en;
        logic [31:0]               pc_new;
        logic                      mispredict;
    } to_writeback_t;

endpackage

`default_nettype wire

// ==== br_cfg.svh ====
`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// number of entries queued between dispatch and execute
// keep this a power of two, the station pointers rely on it
`define BR_STATION_DEPTH 4

// width of the reorder buffer tag carried with each branch
`define BR_ROB_IDX_W 5

// room for later tuning of the cluster
// the link address offset stays fixed at 4 for RV32I
// (no compressed instructions in this core)
`define BR_LINK_OFFSET 32'd4

`endif
